// File: run.sh
#!/usr/bin/env bash
# build the video testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_video -f video.f -o sim_video \
	&& ./obj_dir/sim_video | tee /dev/stderr | grep -q "STATUS: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb_video.sv
// tb_video module: clock, reset, stimulus table, DUT and checker instances, timeout
`timescale 1ns/10ps

module tb_video;
	import video_pkg::*;

	typedef struct packed {
		vpage_t      vpage;
		vconf_t      vconf;
		logic        v60hz;
		logic [8:0]  gx_offs;
		logic [15:0] txt_char;	// xor mask for the per-line random codes
		logic [4:0]  go_offs;	// expected fetch lead
		logic [8:0]  lines;	// expected lines per frame
	} row_t;

	localparam int NUM_ROWS = 8;
	localparam int FRAME    = int'(H_TOTAL) * int'(V_TOTAL_50);	// longest frame
	localparam int LIMIT    = NUM_ROWS * 3 * FRAME + FRAME;	// 3 frames per row plus slack

	row_t              rows [NUM_ROWS];
	row_t              cur;
	logic              clk;
	logic              rst_n;
	reg_wr_t           cpu_wr;
	logic [8:0]        gx_offs;
	logic [15:0]       txt_char;
	logic              hold;
	logic              new_line;
	integer            seed;
	integer            rnd;
	int                cycles;
	logic              frame_start;
	logic              line_start;
	rpos_t             rpos;
	win_t              win;
	fetch_t            fetch;
	logic [1:0]        render_mode;
	logic              tv_hires;
	logic              vga_hires;
	logic              nogfx;
	logic              notsu;
	logic [9:0]        x_offs_mode;
	vaddr_t            video_addr;
	vbw_t              video_bw;
	logic [4:0]        go_offs;
	int                win_errs;
	int                mode_errs;
	int                addr_errs;
	int                frame_errs;

	video_top dut0 (.clk, .rst_n, .cpu_wr, .gx_offs, .txt_char, .frame_start, .line_start,
		.rpos, .win, .fetch, .render_mode, .tv_hires, .vga_hires, .nogfx, .notsu,
		.x_offs_mode, .video_addr, .video_bw, .go_offs);

	video_checker chk0 (.clk, .rst_n, .cpu_wr, .gx_offs, .txt_char, .hold,
		.row_go_offs(cur.go_offs), .row_lines(cur.lines), .frame_start, .line_start,
		.rpos, .win, .fetch, .render_mode, .tv_hires, .vga_hires, .nogfx, .notsu,
		.x_offs_mode, .video_addr, .video_bw, .go_offs, .win_errs, .mode_errs,
		.addr_errs, .frame_errs);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		cpu_wr <= '{wr: 1'b1, addr: addr, data: data};
	endtask

	task automatic wait_frames(input int n);
		for (int k = 0; k < n; k++) begin
			@(negedge clk);
			while (!frame_start)
				@(negedge clk);
		end
	endtask

	// new character pair every line
	always @(negedge clk)
		new_line <= line_start;
	always @(posedge clk) begin
		if (new_line) begin
			rnd = $random(seed);
			txt_char <= cur.txt_char ^ rnd[15:0];
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		// vpage, vconf {rres, nogfx, notsu, -, vmod}, 60 hz, gx_offs, txt mask, go_offs, lines
		rows[0] = '{8'h05, 8'h00, 1'b0, 9'h000, 16'h4142, 5'd18, 9'd320};
		rows[1] = '{8'h3A, 8'h41, 1'b1, 9'h0A5, 16'h1234, 5'd6, 9'd264};
		rows[2] = '{8'hC7, 8'h82, 1'b0, 9'h1FF, 16'hABCD, 5'd4, 9'd320};
		rows[3] = '{8'h9E, 8'hC3, 1'b1, 9'h013, 16'h5A5A, 5'd10, 9'd264};
		rows[4] = '{8'h11, 8'h33, 1'b0, 9'h100, 16'h00FF, 5'd10, 9'd320};
		rows[5] = '{8'hF0, 8'h60, 1'b1, 9'h0FE, 16'hC3A5, 5'd18, 9'd264};
		rows[6] = '{8'h2B, 8'hD2, 1'b1, 9'h155, 16'h7E81, 5'd4, 9'd264};
		rows[7] = '{8'h7F, 8'h85, 1'b0, 9'h0AA, 16'h0F0F, 5'd6, 9'd320};
		rst_n    = 1'b0;
		cpu_wr   = '0;
		gx_offs  = '0;
		txt_char = '0;
		hold     = 1'b0;
		new_line = 1'b0;
		cur      = '0;
		cycles   = 0;
		seed     = 11011;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			@(posedge clk);
			cur     <= rows[i];
			gx_offs <= rows[i].gx_offs;	// not shadowed
			write_reg(RA_VPAGE, rows[i].vpage);	// lands mid-frame
			write_reg(RA_VCONF, rows[i].vconf);
			write_reg(RA_VCTL, {7'd0, rows[i].v60hz});
			write_reg(8'h03, ~rows[i].vconf);	// unknown address
			@(posedge clk);
			cpu_wr <= '0;
			wait_frames(2);
			@(posedge clk);
			hold <= 1'b1;
			wait_frames(1);
			@(posedge clk);
			hold <= 1'b0;
		end
		@(negedge clk);
		$display("errors: window %0d mode %0d address %0d frame %0d",
			win_errs, mode_errs, addr_errs, frame_errs);
		if (win_errs + mode_errs + addr_errs + frame_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: video.f
video_pkg.sv
video_regs.sv
video_raster.sv
video_mode.sv
video_top.sv
video_properties.sv
video_checker.sv
tb_video.sv

// File: video_checker.sv
// video_checker module: reference model of the mode decoder, shadow registers and frame length
`timescale 1ns/10ps

module video_checker (
	input  logic               clk,
	input  logic               rst_n,
	input  video_pkg::reg_wr_t cpu_wr,	// writes of the applied row
	input  logic [8:0]         gx_offs,
	input  logic [15:0]        txt_char,
	input  logic               hold,	// row settled, row columns apply
	input  logic [4:0]         row_go_offs,
	input  logic [8:0]         row_lines,
	input  logic               frame_start,
	input  logic               line_start,
	input  video_pkg::rpos_t   rpos,
	input  video_pkg::win_t    win,
	input  video_pkg::fetch_t  fetch,
	input  logic [1:0]         render_mode,
	input  logic               tv_hires,
	input  logic               vga_hires,
	input  logic               nogfx,
	input  logic               notsu,
	input  logic [9:0]         x_offs_mode,
	input  video_pkg::vaddr_t  video_addr,
	input  video_pkg::vbw_t    video_bw,
	input  logic [4:0]         go_offs,
	output int                 win_errs,
	output int                 mode_errs,
	output int                 addr_errs,
	output int                 frame_errs
);
	import video_pkg::*;

	vcfg_t      stg;	// staging model
	vcfg_t      act;	// active config model
	win_t       ew;	// expected window
	logic [1:0] vmod;
	logic [4:0] e_bw;
	logic [4:0] e_go;
	logic       e_hi;
	logic       e_pix;
	int         e_row;
	int         g;
	int         xo;
	int         hpos;	// clock inside the line
	int         vpos;	// line inside the frame
	logic       pos_ok;	// raster position known
	int         lines;	// line_start count this frame
	int         want_lines;	// 0 until the first frame
	int         shown;	// mismatch lines printed

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp,
		inout int errs);
		if (got !== exp) begin
			errs++;
			if (shown < 40)	// keep the log readable
				$display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
			shown++;
		end
	endtask

	// window per resolution, vertical limits differ for 60 hz
	function automatic win_t window_for(input logic [1:0] rres, input logic v60);
		win_t w;
		case (rres)
			2'd0: w = {9'd140, 9'd396, v60 ? 9'd46 : 9'd80, v60 ? 9'd238 : 9'd272, 6'd34};
			2'd1: w = {9'd108, 9'd428, v60 ? 9'd42 : 9'd76, v60 ? 9'd242 : 9'd276, 6'd42};
			2'd2: w = {9'd108, 9'd428, v60 ? 9'd22 : 9'd56, v60 ? 9'd262 : 9'd296, 6'd42};
			default: w = {9'd88, 9'd448, v60 ? 9'd22 : 9'd32, v60 ? 9'd262 : 9'd320, 6'd47};
		endcase
		return w;
	endfunction

	// dram word address, worked out in plain arithmetic
	function automatic vaddr_t addr_for(input vcfg_t c, input rpos_t p, input logic [15:0] ch);
		int pg;
		int r;
		int k;
		int a;
		pg = int'(c.vpage);
		r  = int'(p.cnt_row);
		k  = int'(p.cnt_col);
		case (c.vconf[1:0])
			M_ZX: begin
				if (k % 2 == 1)
					a = 3072 + (r / 8 % 32) * 16 + k / 2 % 16;	// attribute words
				else
					a = (r / 64 % 4) * 1024 + (r % 8) * 128 + (r / 8 % 8) * 16 + k / 2 % 16;
				a = a + pg * 8192;
			end
			M_HC: a = (pg / 8) * 65536 + r * 128 + k % 128;
			M_XC: a = (pg / 16) * 131072 + r * 256 + k;
			default: begin
				case (k % 4)
					0: a = (pg % 2) * 8192 + (r / 8 % 64) * 128 + k / 4;	// char
					1: a = (pg % 2) * 8192 + (r / 8 % 64) * 128 + 64 + k / 4;	// attr
					2: a = (1 - pg % 2) * 8192 + int'(ch[7:0]) * 4 + r / 2 % 4;
					default: a = (1 - pg % 2) * 8192 + int'(ch[15:8]) * 4 + r / 2 % 4;
				endcase
				a = a + (pg / 2) * 16384;
			end
		endcase
		return vaddr_t'(a);
	endfunction

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (!rst_n) begin
			stg        = '0;
			act        = '0;	// zx, 50 hz, page 0
			hpos       = 0;
			vpos       = 0;
			pos_ok     = 1'b0;
			lines      = 0;
			want_lines = 0;
			shown      = 0;
			win_errs   = 0;
			mode_errs  = 0;
			addr_errs  = 0;
			frame_errs = 0;
		end else begin
			if (line_start) begin
				hpos = 0;
				vpos = frame_start ? 0 : vpos + 1;
			end else begin
				hpos++;
			end
			if (frame_start)
				pos_ok = 1'b1;
			vmod = act.vconf[1:0];
			case (vmod)
				M_ZX: {e_bw, e_go, e_hi} = {5'b11001, 5'd18, 1'b0};	// 1 of 8
				M_HC: {e_bw, e_go, e_hi} = {5'b01001, 5'd6, 1'b0};	// 1 of 4
				M_XC: {e_bw, e_go, e_hi} = {5'b00001, 5'd4, 1'b0};	// 1 of 2
				default: {e_bw, e_go, e_hi} = {5'b11100, 5'd10, 1'b1};	// 4 of 8
			endcase
			g  = int'(gx_offs);
			xo = (vmod == M_XC) ? (g / 2) * 4 + g % 2 : (g / 2) * 2 + g % 2;
			ew = window_for(act.vconf[7:6], act.v60hz);
			check("window", 64'(win), 64'(ew), win_errs);
			check("video_bw", 64'(video_bw), 64'(e_bw), mode_errs);
			check("go_offs", 64'(go_offs), 64'(e_go), mode_errs);
			check("tv_hires", 64'(tv_hires), 64'(e_hi), mode_errs);
			check("render_mode", 64'(render_mode), 64'(vmod), mode_errs);
			check("nogfx", 64'(nogfx), 64'(act.vconf[5]), mode_errs);
			check("notsu", 64'(notsu), 64'(act.vconf[4]), mode_errs);
			check("x_offs_mode", 64'(x_offs_mode), 64'(xo), mode_errs);
			check("video_addr", 64'(video_addr), 64'(addr_for(act, rpos, txt_char)), addr_errs);
			if (pos_ok) begin
				// pixel rate doubles in text mode
				e_pix = e_hi ? (hpos % 2 == 0) : (hpos % 4 == 0);
				check("pix_stb", 64'(fetch.pix_stb), 64'(e_pix), mode_errs);
				check("fetch_stb off c3", 64'(fetch.fetch_stb && (hpos % 4 != 0)), 64'(0),
					mode_errs);
				if (vpos >= int'(ew.vpix_beg) && vpos < int'(ew.vpix_end))
					e_row = vpos - int'(ew.vpix_beg);
				else
					e_row = 0;	// outside the window
				check("cnt_row", 64'(rpos.cnt_row), 64'(e_row), addr_errs);
			end
			if (hold) begin
				check("row go_offs", 64'(go_offs), 64'(row_go_offs), mode_errs);
				check("vga_hires", 64'(vga_hires), 64'(e_hi), mode_errs);	// settled lines
			end
			if (frame_start) begin
				if (want_lines != 0)
					check("lines per frame", 64'(lines), 64'(want_lines), frame_errs);
				if (hold)
					check("row lines per frame", 64'(lines), 64'(row_lines), frame_errs);
				act        = stg;	// seen from the next cycle on
				want_lines = act.v60hz ? 264 : 320;
				lines      = 0;
			end
			if (line_start)
				lines++;
			if (cpu_wr.wr) begin	// lands in staging at the next edge
				case (cpu_wr.addr)
					RA_VPAGE: stg.vpage = cpu_wr.data;
					RA_VCONF: stg.vconf = cpu_wr.data;
					RA_VCTL:  stg.v60hz = cpu_wr.data[0];
					default: ;
				endcase
			end
		end
	end

endmodule

// File: video_mode.sv
// video_mode module: window limits, fetch selectors and strobes, bandwidth and dram video address
`timescale 1ns/10ps

module video_mode (
	input  logic             clk,
	input  video_pkg::vcfg_t vcfg,
	input  video_pkg::rpos_t rpos,
	input  logic [8:0]       gx_offs,
	input  logic [15:0]      txt_char,	// char code pair fetched last
	input  logic             c3,
	input  logic             f1,
	input  logic             pix_start,
	input  logic             line_start,
	output video_pkg::win_t  win,
	output logic [4:0]       go_offs,
	output video_pkg::fetch_t fetch,
	output logic [1:0]       render_mode,
	output logic             tv_hires,
	output logic             vga_hires,
	output logic             nogfx,
	output logic             notsu,
	output logic [9:0]       x_offs_mode,
	output video_pkg::vaddr_t video_addr,
	output video_pkg::vbw_t  video_bw
);
	import video_pkg::*;

	logic [1:0]  vmod;
	logic [1:0]  rres;
	logic        ftch;	// fetch due by fetch_cnt
	logic [3:0]  txt_sel;
	logic [1:0]  txt_bsl;
	logic [11:0] addr_zx_gfx;
	logic [11:0] addr_zx_atr;
	logic [13:0] addr_tx;
	vaddr_t      addr_zx;
	vaddr_t      addr_16c;
	vaddr_t      addr_256c;
	vaddr_t      addr_text;

	assign vmod  = vcfg.vconf[1:0];
	assign rres  = vcfg.vconf[7:6];
	assign notsu = vcfg.vconf[4];
	assign nogfx = vcfg.vconf[5];

	assign render_mode = vmod;	// renderer codes match mode codes
	assign tv_hires    = (vmod == M_TX);	// only text runs at double pixel rate

	// vga side sees the rate change at line boundary only
	always_ff @(posedge clk)
		if (line_start)
			vga_hires <= tv_hires;

	// x scroll, 256c has one byte per pixel
	assign x_offs_mode = {(vmod == M_XC) ? {gx_offs[8:1], 1'b0} : {1'b0, gx_offs[8:1]},
		gx_offs[0]};

	// resolution table, 50 and 60 hz vertical variants
	always_comb begin
		case (rres)
			2'd0: begin	// 256x192
				win.hpix_beg = 9'd140;
				win.hpix_end = 9'd396;
				win.vpix_beg = vcfg.v60hz ? 9'd46 : 9'd80;
				win.vpix_end = vcfg.v60hz ? 9'd238 : 9'd272;
				win.x_tiles  = 6'd34;
			end
			2'd1: begin	// 320x200
				win.hpix_beg = 9'd108;
				win.hpix_end = 9'd428;
				win.vpix_beg = vcfg.v60hz ? 9'd42 : 9'd76;
				win.vpix_end = vcfg.v60hz ? 9'd242 : 9'd276;
				win.x_tiles  = 6'd42;
			end
			2'd2: begin	// 320x240
				win.hpix_beg = 9'd108;
				win.hpix_end = 9'd428;
				win.vpix_beg = vcfg.v60hz ? 9'd22 : 9'd56;
				win.vpix_end = vcfg.v60hz ? 9'd262 : 9'd296;
				win.x_tiles  = 6'd42;
			end
			default: begin	// 360x288, no border
				win.hpix_beg = 9'd88;
				win.hpix_end = 9'd448;
				win.vpix_beg = vcfg.v60hz ? 9'd22 : 9'd32;
				win.vpix_end = vcfg.v60hz ? 9'd262 : 9'd320;
				win.x_tiles  = 6'd47;
			end
		endcase
	end

	// text fetch cycle on col[1:0]
	always_comb begin
		case (rpos.cnt_col[1:0])
			2'd1: begin
				txt_sel = 4'b0011;	// char codes
				txt_bsl = 2'b10;
			end
			2'd2: begin
				txt_sel = 4'b1100;	// attributes
				txt_bsl = 2'b10;
			end
			2'd3: begin
				txt_sel = 4'b0001;	// glyph 0
				txt_bsl = {2{rpos.cnt_row[0]}};	// byte lane by odd line
			end
			default: begin
				txt_sel = 4'b0010;	// glyph 1
				txt_bsl = {2{rpos.cnt_row[0]}};
			end
		endcase
	end

	// dram layouts
	assign addr_zx_gfx = {rpos.cnt_row[7:6], rpos.cnt_row[2:0], rpos.cnt_row[5:3],
		rpos.cnt_col[4:1]};	// zx third/line/row interleave
	assign addr_zx_atr = {3'b110, rpos.cnt_row[7:3], rpos.cnt_col[4:1]};	// attrs at 0x1800
	assign addr_zx     = {vcfg.vpage, 1'b0, rpos.cnt_col[0] ? addr_zx_atr : addr_zx_gfx};
	assign addr_16c    = {vcfg.vpage[7:3], rpos.cnt_row, rpos.cnt_col[6:0]};
	assign addr_256c   = {vcfg.vpage[7:4], rpos.cnt_row, rpos.cnt_col};
	always_comb begin
		case (rpos.cnt_col[1:0])
			2'd0: addr_tx = {vcfg.vpage[0], rpos.cnt_row[8:3], 1'b0, rpos.cnt_col[7:2]};
			2'd1: addr_tx = {vcfg.vpage[0], rpos.cnt_row[8:3], 1'b1, rpos.cnt_col[7:2]};
			2'd2: addr_tx = {~vcfg.vpage[0], 3'b000, txt_char[7:0], rpos.cnt_row[2:1]};
			default: addr_tx = {~vcfg.vpage[0], 3'b000, txt_char[15:8], rpos.cnt_row[2:1]};
		endcase
	end
	assign addr_text = {vcfg.vpage[7:1], addr_tx};	// font in the odd/even sibling page

	// per-mode offset, bandwidth, selectors, address
	always_comb begin
		fetch.fetch_bsl = 2'b10;
		case (vmod)
			M_ZX: begin
				go_offs         = 5'd18;
				video_bw        = {BW_8, BU_1};	// 1 of 8
				fetch.fetch_sel = {~rpos.cptr, ~rpos.cptr, rpos.cptr, rpos.cptr};
				ftch            = &rpos.fetch_cnt;
				video_addr      = addr_zx;
			end
			M_HC: begin
				go_offs         = 5'd6;
				video_bw        = {BW_4, BU_1};	// 1 of 4
				fetch.fetch_sel = {~rpos.cptr, ~rpos.cptr, 2'b11};
				ftch            = &rpos.fetch_cnt[1:0];
				video_addr      = addr_16c;
			end
			M_XC: begin
				go_offs         = 5'd4;
				video_bw        = {BW_2, BU_1};	// 1 of 2
				fetch.fetch_sel = {~rpos.cptr, ~rpos.cptr, 2'b11};
				ftch            = rpos.fetch_cnt[0];
				video_addr      = addr_256c;
			end
			default: begin	// text
				go_offs         = 5'd10;
				video_bw        = {BW_8, BU_4};	// 4 of 8
				fetch.fetch_sel = txt_sel;
				fetch.fetch_bsl = txt_bsl;
				ftch            = &rpos.fetch_cnt;
				video_addr      = addr_text;
			end
		endcase
		fetch.fetch_stb = (pix_start | ftch) & c3;	// first fetch right at pix_start
		fetch.pix_stb   = tv_hires ? f1 : c3;
	end

endmodule

// File: video_pkg.sv
// video package with typedefs, mode and register codes, timing constants and bus structs
package video_pkg;

	typedef logic [7:0]  vpage_t;	// video page base, upper dram bits
	typedef logic [7:0]  vconf_t;	// rres[7:6] nogfx[5] notsu[4] vmod[1:0]
	typedef logic [8:0]  coord_t;	// raster coordinate or window limit
	typedef logic [20:0] vaddr_t;	// dram word address
	typedef logic [4:0]  vbw_t;	// {total cycles, needed cycles one-hot}

	// video modes, also used as render mode codes
	localparam logic [1:0] M_ZX = 2'd0;	// zx spectrum screen
	localparam logic [1:0] M_HC = 2'd1;	// 16 colour
	localparam logic [1:0] M_XC = 2'd2;	// 256 colour
	localparam logic [1:0] M_TX = 2'd3;	// text

	localparam logic [7:0] RA_VPAGE = 8'h00;
	localparam logic [7:0] RA_VCONF = 8'h01;
	localparam logic [7:0] RA_VCTL  = 8'h02;	// bit 0 selects 60 hz

	localparam coord_t H_TOTAL    = 9'd448;	// clocks per line
	localparam coord_t V_TOTAL_50 = 9'd320;	// lines per frame
	localparam coord_t V_TOTAL_60 = 9'd264;

	// dram bandwidth, total cycles in the slot
	localparam logic [1:0] BW_2 = 2'b00;
	localparam logic [1:0] BW_4 = 2'b01;
	localparam logic [1:0] BW_8 = 2'b11;
	// cycles actually used
	localparam logic [2:0] BU_1 = 3'b001;
	localparam logic [2:0] BU_4 = 3'b100;

	typedef struct packed {
		logic       wr;	// write strobe, no ack
		logic [7:0] addr;
		logic [7:0] data;
	} reg_wr_t;

	typedef struct packed {
		vpage_t vpage;
		vconf_t vconf;
		logic   v60hz;
	} vcfg_t;

	typedef struct packed {
		coord_t     hpix_beg;
		coord_t     hpix_end;
		coord_t     vpix_beg;
		coord_t     vpix_end;
		logic [5:0] x_tiles;	// tiles per line for the tile engine
	} win_t;

	typedef struct packed {
		logic [7:0] cnt_col;	// fetch column
		coord_t     cnt_row;	// line inside the window
		logic [3:0] fetch_cnt;
		logic       cptr;	// gfx/attr toggle
	} rpos_t;

	typedef struct packed {
		logic [3:0] fetch_sel;
		logic [1:0] fetch_bsl;
		logic       fetch_stb;
		logic       pix_stb;
	} fetch_t;

endpackage

// File: video_properties.sv
// video_properties module: raster pulse and config shadow assertions, bind into video_raster
`timescale 1ns/10ps

module video_properties (
	input logic             clk,
	input logic             rst_n,
	input logic             line_start,
	input logic             frame_start,
	input logic             c3,
	input video_pkg::vcfg_t vcfg	// active config as the raster sees it
);
	line_single: assert property (@(posedge clk) disable iff (!rst_n)
		line_start |=> !line_start) else $error("line_start high in two cycles in a row");
	frame_single: assert property (@(posedge clk) disable iff (!rst_n)
		frame_start |=> !frame_start) else $error("frame_start high in two cycles in a row");
	frame_on_line: assert property (@(posedge clk) disable iff (!rst_n)
		frame_start |-> line_start) else $error("frame_start without line_start");
	c3_single: assert property (@(posedge clk) disable iff (!rst_n)
		c3 |=> !c3) else $error("c3 high in two cycles in a row");
	// config only moves right after the frame boundary
	cfg_shadow: assert property (@(posedge clk) disable iff (!rst_n)
		(vcfg != $past(vcfg)) |-> $past(frame_start)) else $error("vcfg changed mid-frame");
endmodule

bind video_raster video_properties props0 (.clk, .rst_n, .line_start, .frame_start, .c3, .vcfg);

// File: video_raster.sv
// video_raster module: line and frame counters, phase divider, fetch and column/row counters
`timescale 1ns/10ps

module video_raster (
	input  logic             clk,
	input  logic             rst_n,
	input  video_pkg::vcfg_t vcfg,
	input  video_pkg::win_t  win,
	input  logic [4:0]       go_offs,
	input  logic             fetch_stb,
	output logic             line_start,
	output logic             frame_start,
	output logic             pix_start,
	output logic             c3,
	output logic             f1,
	output video_pkg::rpos_t rpos
);
	import video_pkg::*;

	coord_t     hcnt;	// 0 .. H_TOTAL-1
	coord_t     vcnt;	// line in frame
	coord_t     v_last;
	coord_t     pix_hpos;	// where fetching begins
	logic [1:0] phase;
	logic       vwin;
	logic       fetch_act;
	logic [7:0] cnt_col;
	logic [3:0] fetch_cnt;
	logic       cptr;
	coord_t     cnt_row;

	assign v_last = vcfg.v60hz ? V_TOTAL_60 - 9'd1 : V_TOTAL_50 - 9'd1;

	// counters park on the last position in reset
	// so the first clock after release starts line 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hcnt  <= H_TOTAL - 9'd1;
			vcnt  <= V_TOTAL_50 - 9'd1;
			phase <= 2'd3;
		end else begin
			phase <= phase + 2'd1;	// stays aligned with hcnt, 448 is a multiple of 4
			if (hcnt == H_TOTAL - 9'd1) begin
				hcnt <= '0;
				vcnt <= (vcnt >= v_last) ? '0 : vcnt + 9'd1;	// >= covers rate switch
			end else begin
				hcnt <= hcnt + 9'd1;
			end
		end
	end

	assign c3 = (phase == 2'd0);	// every 4th clock
	assign f1 = ~phase[0];	// every 2nd clock
	assign line_start  = (hcnt == '0);
	assign frame_start = line_start & (vcnt == '0);

	assign vwin     = (vcnt >= win.vpix_beg) && (vcnt < win.vpix_end);
	// fetch runs ahead of the pixels by go_offs fetch slots
	assign pix_hpos  = win.hpix_beg - {2'b00, go_offs, 2'b00};
	assign pix_start = vwin & (hcnt == pix_hpos);
	assign cnt_row   = vwin ? vcnt - win.vpix_beg : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_act <= 1'b0;
			fetch_cnt <= '0;
			cnt_col   <= '0;
			cptr      <= 1'b0;
		end else begin
			if (pix_start)
				fetch_act <= 1'b1;
			else if (line_start)
				fetch_act <= 1'b0;	// idle until next window line
			if (pix_start)
				fetch_cnt <= '0;
			else if (c3 && fetch_act)
				fetch_cnt <= fetch_cnt + 4'd1;
			if (pix_start)
				cnt_col <= '0;
			else if (fetch_stb)
				cnt_col <= cnt_col + 8'd1;
			if (fetch_stb)
				cptr <= ~cptr;	// gfx/attr alternation
		end
	end

	always_comb begin
		rpos.cnt_col   = cnt_col;
		rpos.cnt_row   = cnt_row;
		rpos.fetch_cnt = fetch_cnt;
		rpos.cptr      = cptr;
	end

endmodule

// File: video_regs.sv
// video_regs module: cpu staging registers and frame-start shadow of the video configuration
`timescale 1ns/10ps

module video_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  video_pkg::reg_wr_t cpu_wr,
	input  logic              frame_start,
	output video_pkg::vcfg_t  vcfg
);
	import video_pkg::*;

	vpage_t stg_vpage;	// staged, not yet visible
	vconf_t stg_vconf;
	logic   stg_v60hz;

	// cpu side, plain strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stg_vpage <= '0;
			stg_vconf <= '0;	// zx mode, rres 0
			stg_v60hz <= 1'b0;	// 50 hz
		end else if (cpu_wr.wr) begin
			case (cpu_wr.addr)
				RA_VPAGE: stg_vpage <= cpu_wr.data;
				RA_VCONF: stg_vconf <= cpu_wr.data;
				RA_VCTL:  stg_v60hz <= cpu_wr.data[0];
				default: ;	// unknown address, dropped
			endcase
		end
	end

	// whole mode switches at once on the frame boundary
	// so the picture never tears mid-frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vcfg <= '0;
		end else if (frame_start) begin
			vcfg.vpage <= stg_vpage;
			vcfg.vconf <= stg_vconf;
			vcfg.v60hz <= stg_v60hz;
		end
	end

endmodule

// File: video_top.sv
// video_top module: registers, raster generator and mode decoder wired together
`timescale 1ns/10ps

module video_top (
	input  logic               clk,
	input  logic               rst_n,
	input  video_pkg::reg_wr_t cpu_wr,
	input  logic [8:0]         gx_offs,
	input  logic [15:0]        txt_char,
	output logic               frame_start,
	output logic               line_start,
	output video_pkg::rpos_t   rpos,
	output video_pkg::win_t    win,
	output video_pkg::fetch_t  fetch,
	output logic [1:0]         render_mode,
	output logic               tv_hires,
	output logic               vga_hires,
	output logic               nogfx,
	output logic               notsu,
	output logic [9:0]         x_offs_mode,
	output video_pkg::vaddr_t  video_addr,
	output video_pkg::vbw_t    video_bw,
	output logic [4:0]         go_offs
);
	import video_pkg::*;

	vcfg_t vcfg;	// active config, frame aligned
	logic  pix_start;
	logic  c3;
	logic  f1;

	video_regs u_regs (
		.clk, .rst_n, .cpu_wr, .frame_start, .vcfg
	);

	video_raster u_raster (
		.clk, .rst_n, .vcfg, .win, .go_offs,
		.fetch_stb(fetch.fetch_stb),	// decoder paces the column counter
		.line_start, .frame_start, .pix_start, .c3, .f1, .rpos
	);

	video_mode u_mode (
		.clk, .vcfg, .rpos, .gx_offs, .txt_char, .c3, .f1, .pix_start, .line_start,
		.win, .go_offs, .fetch, .render_mode, .tv_hires, .vga_hires, .nogfx, .notsu,
		.x_offs_mode, .video_addr, .video_bw
	);

endmodule
